// File: logic/qdr_cfg_pkg.sv
`default_nettype none

package qdr_cfg_pkg;

  // read data bits on a full width QDR port.
  localparam int DATA_WIDTH_DEFAULT = 18;

  // taps available in each per bit input delay line.
  localparam int TAP_COUNT_DEFAULT = 32;

  // the settle window and the sample window are equally long.
  localparam int WINDOW_CYCLES = 32;

endpackage

`default_nettype wire

// File: logic/qdr_train_pkg.sv
`default_nettype none

package qdr_train_pkg;

  // one captured bit as {rise, fall}.
  typedef logic [1:0] sample_t;

  // a good capture toggles between the edges, so both equal codes are malformed.
  localparam sample_t SAMPLE_HIGH = 2'b11;
  localparam sample_t SAMPLE_LOW  = 2'b00;

  typedef enum logic [2:0] {
    SEQ_IDLE        = 3'd0,
    SEQ_RESET_BIT   = 3'd1,
    SEQ_MEASURE     = 3'd2,
    SEQ_STEP        = 3'd3,
    SEQ_SEEK_CENTRE = 3'd4,
    SEQ_REPORT      = 3'd5,
    SEQ_DONE        = 3'd6
  } seq_state_t;

  typedef enum logic [1:0] {
    CHK_DONE   = 2'b00,
    CHK_SETTLE = 2'b01,
    CHK_SAMPLE = 2'b10
  } check_state_t;

endpackage

`default_nettype wire

// File: logic/qdr_tap_if.sv
`timescale 1ns/1ps
`default_nettype none

interface qdr_tap_if #(
  parameter int DATA_WIDTH = qdr_cfg_pkg::DATA_WIDTH_DEFAULT
);

  localparam int BIT_W = $clog2(DATA_WIDTH);

  logic [BIT_W-1:0] bit_select; // held for the whole training of one bit.
  logic             tap_rst;
  logic             tap_en;
  logic             tap_inc;    // 1 moves the delay up by one tap.

  modport ctrl (
    output bit_select,
    output tap_rst,
    output tap_en,
    output tap_inc
  );

  modport lane (
    input bit_select,
    input tap_rst,
    input tap_en,
    input tap_inc
  );

endinterface

`default_nettype wire

// File: logic/qdr_lane_select.sv
`timescale 1ns/1ps
`default_nettype none

module qdr_lane_select #(
  parameter int DATA_WIDTH = qdr_cfg_pkg::DATA_WIDTH_DEFAULT
) (
  input  wire                    clk,
  input  wire   [DATA_WIDTH-1:0] q_rise,
  input  wire   [DATA_WIDTH-1:0] q_fall,
  qdr_tap_if.lane                tap,
  output qdr_train_pkg::sample_t sample,
  output logic  [DATA_WIDTH-1:0] dly_rst,
  output logic  [DATA_WIDTH-1:0] dly_en,
  output logic  [DATA_WIDTH-1:0] dly_inc_dec_n
);

  logic [DATA_WIDTH-1:0] q_rise_r;
  logic [DATA_WIDTH-1:0] q_fall_r;

  // the capture flops are the first stage after the IO registers.
  always_ff @(posedge clk) begin
    q_rise_r <= q_rise;
    q_fall_r <= q_fall;
  end

  // second stage narrows the bus down to the bit being trained.
  always_ff @(posedge clk) begin
    sample <= {q_rise_r[tap.bit_select], q_fall_r[tap.bit_select]};
  end

  // commands reach the delay lines in the same cycle.
  always_comb begin
    dly_rst = DATA_WIDTH'(tap.tap_rst) << tap.bit_select;
    dly_en  = DATA_WIDTH'(tap.tap_en) << tap.bit_select;
  end

  assign dly_inc_dec_n = {DATA_WIDTH{tap.tap_inc}}; // every line shares one direction.

endmodule

`default_nettype wire

// File: logic/qdr_window_check.sv
`timescale 1ns/1ps
`default_nettype none

module qdr_window_check (
  input  wire                    clk,
  input  wire                    rst_n,
  qdr_tap_if.lane                tap,
  input  wire qdr_train_pkg::sample_t sample,
  output logic                   check_done,
  output logic                   check_good
);

  localparam int WINDOW = qdr_cfg_pkg::WINDOW_CYCLES;
  localparam int CNT_W  = $clog2(WINDOW);

  qdr_train_pkg::check_state_t state;
  logic [CNT_W-1:0]            cnt;
  qdr_train_pkg::sample_t      first;
  logic                        cmd;
  logic                        settle_end;
  logic                        malformed;

  assign cmd        = tap.tap_rst | tap.tap_en;
  assign settle_end = (state == qdr_train_pkg::CHK_SETTLE) && (cnt == CNT_W'(WINDOW - 2));
  assign malformed  = (sample == qdr_train_pkg::SAMPLE_HIGH) ||
                      (sample == qdr_train_pkg::SAMPLE_LOW);

  // settle and sample together span twice the window, counted from the command cycle.
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state      <= qdr_train_pkg::CHK_DONE;
      cnt        <= '0;
      check_good <= 1'b0;
    end else if (cmd) begin
      state      <= qdr_train_pkg::CHK_SETTLE; // a new command always restarts the window.
      cnt        <= '0;
      check_good <= 1'b1;
    end else begin
      case (state)
        qdr_train_pkg::CHK_SETTLE: begin
          cnt <= cnt + 1'b1;
          if (settle_end) begin
            state <= qdr_train_pkg::CHK_SAMPLE;
            cnt   <= '0;
            if (malformed) begin
              check_good <= 1'b0; // the first sample itself must be well formed.
            end
          end
        end
        qdr_train_pkg::CHK_SAMPLE: begin
          cnt <= cnt + 1'b1;
          if (malformed || sample != first) begin
            check_good <= 1'b0;
          end
          if (cnt == CNT_W'(WINDOW - 1)) begin
            state <= qdr_train_pkg::CHK_DONE;
          end
        end
        default: begin
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (settle_end && !cmd) begin
      first <= sample;
    end
  end

  assign check_done = (state == qdr_train_pkg::CHK_DONE);

endmodule

`default_nettype wire

// File: logic/qdr_train_seq.sv
`timescale 1ns/1ps
`default_nettype none

module qdr_train_seq #(
  parameter int DATA_WIDTH = qdr_cfg_pkg::DATA_WIDTH_DEFAULT,
  parameter int TAP_COUNT  = qdr_cfg_pkg::TAP_COUNT_DEFAULT
) (
  input  wire                           clk,
  input  wire                           rst_n,
  input  wire                           train_start,
  input  wire                           check_done,
  input  wire                           check_good,
  qdr_tap_if.ctrl                       tap,
  output logic                          train_busy,
  output logic                          train_done,
  output logic                          result_valid,
  output logic [$clog2(DATA_WIDTH)-1:0] result_bit,
  output logic [$clog2(TAP_COUNT)-1:0]  result_center,
  output logic                          result_found
);

  localparam int BIT_W = $clog2(DATA_WIDTH);
  localparam int TAP_W = $clog2(TAP_COUNT);

  qdr_train_pkg::seq_state_t state;
  logic [BIT_W-1:0]          bit_idx;
  logic [TAP_W-1:0]          tap_idx;    // position of the selected delay line.
  logic [TAP_W-1:0]          first_good;
  logic [TAP_W-1:0]          last_good;
  logic                      have_good;
  logic                      cmd_rst;
  logic                      cmd_en;
  logic [TAP_W:0]            tap_sum;
  logic [TAP_W-1:0]          center;
  logic                      judge;
  logic                      last_tap;
  logic                      last_bit;

  assign tap_sum  = {1'b0, first_good} + {1'b0, last_good};
  assign center   = have_good ? tap_sum[TAP_W:1] : '0;
  // check_done is stale in the cycle that carries the command.
  assign judge    = check_done && !cmd_rst && !cmd_en;
  assign last_tap = (tap_idx == TAP_W'(TAP_COUNT - 1));
  assign last_bit = (bit_idx == BIT_W'(DATA_WIDTH - 1));

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state      <= qdr_train_pkg::SEQ_IDLE;
      bit_idx    <= '0;
      tap_idx    <= '0;
      first_good <= '0;
      last_good  <= '0;
      have_good  <= 1'b0;
      cmd_rst    <= 1'b0;
      cmd_en     <= 1'b0;
    end else begin
      cmd_rst <= 1'b0;
      cmd_en  <= 1'b0;
      case (state)
        qdr_train_pkg::SEQ_IDLE,
        qdr_train_pkg::SEQ_DONE: begin
          if (train_start) begin
            bit_idx <= '0;
            state   <= qdr_train_pkg::SEQ_RESET_BIT;
          end
        end
        qdr_train_pkg::SEQ_RESET_BIT: begin
          cmd_rst    <= 1'b1;
          tap_idx    <= '0;
          have_good  <= 1'b0;
          first_good <= '0;
          last_good  <= '0;
          state      <= qdr_train_pkg::SEQ_MEASURE;
        end
        qdr_train_pkg::SEQ_MEASURE: begin
          if (judge) begin
            if (check_good) begin
              if (!have_good) begin
                first_good <= tap_idx;
              end
              last_good <= tap_idx;
              have_good <= 1'b1;
            end
            if ((have_good && !check_good) || last_tap) begin
              cmd_rst <= 1'b1; // back to tap 0 before walking up to the centre.
              tap_idx <= '0;
              state   <= qdr_train_pkg::SEQ_SEEK_CENTRE;
            end else begin
              state <= qdr_train_pkg::SEQ_STEP;
            end
          end
        end
        qdr_train_pkg::SEQ_STEP: begin
          cmd_en  <= 1'b1;
          tap_idx <= tap_idx + 1'b1;
          state   <= qdr_train_pkg::SEQ_MEASURE;
        end
        qdr_train_pkg::SEQ_SEEK_CENTRE: begin
          if (tap_idx == center) begin
            state <= qdr_train_pkg::SEQ_REPORT;
          end else begin
            cmd_en  <= 1'b1;
            tap_idx <= tap_idx + 1'b1;
          end
        end
        qdr_train_pkg::SEQ_REPORT: begin
          if (last_bit) begin
            state <= qdr_train_pkg::SEQ_DONE;
          end else begin
            bit_idx <= bit_idx + 1'b1;
            state   <= qdr_train_pkg::SEQ_RESET_BIT;
          end
        end
        default: begin
          state <= qdr_train_pkg::SEQ_IDLE;
        end
      endcase
    end
  end

  assign tap.bit_select = bit_idx;
  assign tap.tap_rst    = cmd_rst;
  assign tap.tap_en     = cmd_en;
  assign tap.tap_inc    = 1'b1; // the scan only ever moves upward.

  assign train_busy    = (state != qdr_train_pkg::SEQ_IDLE) && (state != qdr_train_pkg::SEQ_DONE);
  assign train_done    = (state == qdr_train_pkg::SEQ_DONE);
  assign result_valid  = (state == qdr_train_pkg::SEQ_REPORT);
  assign result_bit    = bit_idx;
  assign result_center = center;
  assign result_found  = have_good;

endmodule

`default_nettype wire

// File: logic/qdr_phy_train_top.sv
`timescale 1ns/1ps
`default_nettype none

module qdr_phy_train_top #(
  parameter int DATA_WIDTH = qdr_cfg_pkg::DATA_WIDTH_DEFAULT,
  parameter int TAP_COUNT  = qdr_cfg_pkg::TAP_COUNT_DEFAULT
) (
  input  wire                           clk,
  input  wire                           rst_n,
  input  wire  [DATA_WIDTH-1:0]         q_rise,
  input  wire  [DATA_WIDTH-1:0]         q_fall,
  input  wire                           train_start,
  output logic [DATA_WIDTH-1:0]         dly_rst,
  output logic [DATA_WIDTH-1:0]         dly_en,
  output logic [DATA_WIDTH-1:0]         dly_inc_dec_n,
  output logic                          train_busy,
  output logic                          train_done,
  output logic                          result_valid,
  output logic [$clog2(DATA_WIDTH)-1:0] result_bit,
  output logic [$clog2(TAP_COUNT)-1:0]  result_center,
  output logic                          result_found
);

  qdr_train_pkg::sample_t sample;
  logic                   check_done;
  logic                   check_good;

  qdr_tap_if #(.DATA_WIDTH(DATA_WIDTH)) tap_bus ();

  qdr_lane_select #(.DATA_WIDTH(DATA_WIDTH)) i_qdr_lane_select (
    .clk           (clk),
    .q_rise        (q_rise),
    .q_fall        (q_fall),
    .tap           (tap_bus.lane),
    .sample        (sample),
    .dly_rst       (dly_rst),
    .dly_en        (dly_en),
    .dly_inc_dec_n (dly_inc_dec_n)
  );

  qdr_window_check i_qdr_window_check (
    .clk        (clk),
    .rst_n      (rst_n),
    .tap        (tap_bus.lane),
    .sample     (sample),
    .check_done (check_done),
    .check_good (check_good)
  );

  qdr_train_seq #(
    .DATA_WIDTH (DATA_WIDTH),
    .TAP_COUNT  (TAP_COUNT)
  ) i_qdr_train_seq (
    .clk           (clk),
    .rst_n         (rst_n),
    .train_start   (train_start),
    .check_done    (check_done),
    .check_good    (check_good),
    .tap           (tap_bus.ctrl),
    .train_busy    (train_busy),
    .train_done    (train_done),
    .result_valid  (result_valid),
    .result_bit    (result_bit),
    .result_center (result_center),
    .result_found  (result_found)
  );

endmodule

`default_nettype wire

// File: sim/qdr_train_properties.sv
`timescale 1ns/1ps
`default_nettype none

module qdr_train_properties #(
  parameter int DATA_WIDTH = qdr_cfg_pkg::DATA_WIDTH_DEFAULT
) (
  input wire                  clk,
  input wire                  rst_n,
  input wire [DATA_WIDTH-1:0] dly_rst,
  input wire [DATA_WIDTH-1:0] dly_en,
  input wire                  train_busy,
  input wire                  train_done,
  input wire                  result_valid
);

  int fail_count = 0;

  en_onehot: assert property (@(posedge clk) disable iff (!rst_n) $onehot0(dly_en))
    else begin
      $error("dly_en drives more than one delay line");
      fail_count++;
    end

  rst_onehot: assert property (@(posedge clk) disable iff (!rst_n) $onehot0(dly_rst))
    else begin
      $error("dly_rst drives more than one delay line");
      fail_count++;
    end

  // the sequencer issues at most one tap command per cycle.
  one_command: assert property (@(posedge clk) disable iff (!rst_n) !(|dly_en && |dly_rst))
    else begin
      $error("dly_en and dly_rst are active in the same cycle");
      fail_count++;
    end

  valid_in_busy: assert property (@(posedge clk) disable iff (!rst_n)
                                  result_valid |-> train_busy)
    else begin
      $error("result_valid seen while train_busy is low");
      fail_count++;
    end

  busy_xor_done: assert property (@(posedge clk) disable iff (!rst_n)
                                  !(train_busy && train_done))
    else begin
      $error("train_busy and train_done are high together");
      fail_count++;
    end

endmodule

bind qdr_phy_train_top qdr_train_properties #(.DATA_WIDTH(DATA_WIDTH)) i_qdr_train_properties (
  .clk          (clk),
  .rst_n        (rst_n),
  .dly_rst      (dly_rst),
  .dly_en       (dly_en),
  .train_busy   (train_busy),
  .train_done   (train_done),
  .result_valid (result_valid)
);

`default_nettype wire

// File: sim/qdr_train_monitor.sv
`timescale 1ns/1ps
`default_nettype none

module qdr_train_monitor #(
  parameter int DATA_WIDTH = 4,
  parameter int TAP_COUNT  = 16
) (
  input  wire                                     clk,
  input  wire                                     rst_n,
  input  wire                                     train_start,
  input  wire  [DATA_WIDTH-1:0]                   dly_rst,
  input  wire  [DATA_WIDTH-1:0]                   dly_en,
  input  wire  [DATA_WIDTH-1:0]                   dly_inc_dec_n,
  input  wire                                     train_busy,
  input  wire                                     train_done,
  input  wire                                     result_valid,
  input  wire  [$clog2(DATA_WIDTH)-1:0]           result_bit,
  input  wire  [$clog2(TAP_COUNT)-1:0]            result_center,
  input  wire                                     result_found,
  input  wire  [95:0]                             run_name,
  input  wire  [DATA_WIDTH*$clog2(TAP_COUNT)-1:0] exp_center,
  input  wire  [DATA_WIDTH-1:0]                   exp_found,
  output int                                      error_count
);

  localparam int TAP_W = $clog2(TAP_COUNT);

  int                    taps [DATA_WIDTH]; // own copy of every delay line position.
  int                    results;
  int                    errors;
  int                    want;
  logic                  started;
  logic                  start_pending;
  logic                  done_q;
  logic [DATA_WIDTH-1:0] allowed;

  initial begin
    for (int b = 0; b < DATA_WIDTH; b++) begin
      taps[b] = 0;
    end
    results       = 0;
    errors        = 0;
    started       = 1'b0;
    start_pending = 1'b0;
    done_q        = 1'b0;
  end

  assign error_count = errors;

  always @(posedge clk) begin
    if (rst_n === 1'b1) begin
      if (!started && (train_busy !== 1'b0 || train_done !== 1'b0 || result_valid !== 1'b0 ||
                       dly_en !== '0 || dly_rst !== '0)) begin
        $display("Fail %s idle outputs: expected all 0, actual busy %b done %b valid %b en %b rst %b",
                 run_name, train_busy, train_done, result_valid, dly_en, dly_rst);
        errors++;
      end
      if (start_pending && (train_busy !== 1'b1 || train_done !== 1'b0)) begin
        $display("Fail %s start: expected busy 1 done 0, actual busy %b done %b",
                 run_name, train_busy, train_done);
        errors++;
      end
      start_pending = 1'b0;
      // only the bit under training may see delay commands.
      allowed = (train_busy === 1'b1 && results < DATA_WIDTH) ? (DATA_WIDTH'(1) << results) : '0;
      if (((dly_en | dly_rst) & ~allowed) != '0) begin
        $display("%s: a delay line other than bit %0d moved, dly_en %b dly_rst %b",
                 run_name, results, dly_en, dly_rst);
        errors++;
      end
      // training only ever moves the delay lines upward.
      if (train_busy === 1'b1 && dly_inc_dec_n !== {DATA_WIDTH{1'b1}}) begin
        $display("Fail %s direction: expected %b, actual %b",
                 run_name, {DATA_WIDTH{1'b1}}, dly_inc_dec_n);
        errors++;
      end
      if (result_valid === 1'b1) begin
        if (results >= DATA_WIDTH) begin
          $display("%s: more results were reported than there are data bits", run_name);
          errors++;
        end else begin
          want = int'(exp_center[results*TAP_W +: TAP_W]);
          if (int'(result_bit) != results) begin
            $display("Fail %s result_bit: expected %0d, actual %0d", run_name, results, result_bit);
            errors++;
          end
          if (result_found !== exp_found[results]) begin
            $display("Fail %s bit %0d found: expected %b, actual %b",
                     run_name, results, exp_found[results], result_found);
            errors++;
          end
          if (int'(result_center) != want) begin
            $display("Fail %s bit %0d center: expected %0d, actual %0d",
                     run_name, results, want, result_center);
            errors++;
          end
          if (taps[result_bit] != int'(result_center)) begin
            $display("Fail %s bit %0d tap position: expected %0d, actual %0d",
                     run_name, result_bit, result_center, taps[result_bit]);
            errors++;
          end
        end
        results++;
      end
      if (train_done === 1'b1 && done_q !== 1'b1 && results != DATA_WIDTH) begin
        $display("%s: training ended after %0d results instead of %0d",
                 run_name, results, DATA_WIDTH);
        errors++;
      end
      done_q = train_done;
      if (train_start === 1'b1 && train_busy === 1'b0) begin
        started       = 1'b1;
        start_pending = 1'b1;
        results       = 0;
      end
      for (int b = 0; b < DATA_WIDTH; b++) begin
        if (dly_rst[b] === 1'b1) begin
          taps[b] = 0;
        end else if (dly_en[b] === 1'b1) begin
          taps[b] = taps[b] + (dly_inc_dec_n[b] ? 1 : -1);
        end
      end
    end
  end

endmodule

`default_nettype wire

// File: sim/tb_qdr_train.sv
`timescale 1ns/1ps
`default_nettype none

module tb_qdr_train;

  localparam int DATA_WIDTH = 4;
  localparam int TAP_COUNT  = 16;
  localparam int BIT_W      = $clog2(DATA_WIDTH);
  localparam int TAP_W      = $clog2(TAP_COUNT);
  localparam int N_RUNS     = 3;
  localparam int WAIT_LIMIT = 20000;

  // each row gives the good taps of bits 0 to 3 and a low of -1 marks a bit with no good tap.
  localparam logic [95:0] RUN_NAME [N_RUNS] = '{"interior", "edges", "mixed"};
  localparam int RUN_LO [N_RUNS][DATA_WIDTH] = '{'{3, 5, -1, 7}, '{0, 11, 0, -1},
                                                 '{-1, 2, 14, 1}};
  localparam int RUN_HI [N_RUNS][DATA_WIDTH] = '{'{9, 12, -1, 7}, '{4, 15, 15, -1},
                                                 '{-1, 3, 15, 14}};

  logic                        clk;
  logic                        rst_n;
  logic [DATA_WIDTH-1:0]       q_rise;
  logic [DATA_WIDTH-1:0]       q_fall;
  logic                        train_start;
  logic [DATA_WIDTH-1:0]       dly_rst;
  logic [DATA_WIDTH-1:0]       dly_en;
  logic [DATA_WIDTH-1:0]       dly_inc_dec_n;
  logic                        train_busy;
  logic                        train_done;
  logic                        result_valid;
  logic [BIT_W-1:0]            result_bit;
  logic [TAP_W-1:0]            result_center;
  logic                        result_found;
  int                          win_lo [DATA_WIDTH];
  int                          win_hi [DATA_WIDTH];
  int                          model_tap [DATA_WIDTH] = '{default: 0};
  logic [95:0]                 cur_name;
  logic [DATA_WIDTH*TAP_W-1:0] exp_center;
  logic [DATA_WIDTH-1:0]       exp_found;
  int                          mon_errors;
  int                          timeouts;

  qdr_phy_train_top #(
    .DATA_WIDTH (DATA_WIDTH),
    .TAP_COUNT  (TAP_COUNT)
  ) i_qdr_phy_train_top (
    .clk           (clk),
    .rst_n         (rst_n),
    .q_rise        (q_rise),
    .q_fall        (q_fall),
    .train_start   (train_start),
    .dly_rst       (dly_rst),
    .dly_en        (dly_en),
    .dly_inc_dec_n (dly_inc_dec_n),
    .train_busy    (train_busy),
    .train_done    (train_done),
    .result_valid  (result_valid),
    .result_bit    (result_bit),
    .result_center (result_center),
    .result_found  (result_found)
  );

  qdr_train_monitor #(
    .DATA_WIDTH (DATA_WIDTH),
    .TAP_COUNT  (TAP_COUNT)
  ) i_qdr_train_monitor (
    .clk           (clk),
    .rst_n         (rst_n),
    .train_start   (train_start),
    .dly_rst       (dly_rst),
    .dly_en        (dly_en),
    .dly_inc_dec_n (dly_inc_dec_n),
    .train_busy    (train_busy),
    .train_done    (train_done),
    .result_valid  (result_valid),
    .result_bit    (result_bit),
    .result_center (result_center),
    .result_found  (result_found),
    .run_name      (cur_name),
    .exp_center    (exp_center),
    .exp_found     (exp_found),
    .error_count   (mon_errors)
  );

  function automatic logic [31:0] next_random(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // one tap counter per data bit stands in for its delay line.
  always @(posedge clk) begin
    for (int b = 0; b < DATA_WIDTH; b++) begin
      if (dly_rst[b] === 1'b1) begin
        model_tap[b] = 0;
      end else if (dly_en[b] === 1'b1) begin
        model_tap[b] = model_tap[b] + (dly_inc_dec_n[b] ? 1 : -1);
      end
    end
  end

  // a bit captures a clean 10 inside its window and a random 11 or 00 outside it.
  initial begin
    logic [31:0] rnd;
    rnd    = 32'h734a;
    q_rise = '0;
    q_fall = '0;
    forever begin
      @(posedge clk);
      #1;
      for (int b = 0; b < DATA_WIDTH; b++) begin
        if (win_lo[b] >= 0 && model_tap[b] >= win_lo[b] && model_tap[b] <= win_hi[b]) begin
          q_rise[b] = 1'b1;
          q_fall[b] = 1'b0;
        end else begin
          rnd       = next_random(rnd);
          q_rise[b] = rnd[9];
          q_fall[b] = rnd[9];
        end
      end
    end
  end

  task automatic load_run(input int r);
    cur_name = RUN_NAME[r];
    for (int b = 0; b < DATA_WIDTH; b++) begin
      win_lo[b] = RUN_LO[r][b];
      win_hi[b] = RUN_HI[r][b];
      if (RUN_LO[r][b] < 0) begin
        exp_found[b]                  = 1'b0;
        exp_center[b*TAP_W +: TAP_W] = '0;
      end else begin
        exp_found[b]                  = 1'b1;
        exp_center[b*TAP_W +: TAP_W] = TAP_W'((RUN_LO[r][b] + RUN_HI[r][b]) / 2);
      end
    end
  endtask

  task automatic pulse_start();
    train_start = 1'b1;
    @(posedge clk);
    #1;
    train_start = 1'b0;
  endtask

  task automatic wait_for_result(output bit ok);
    int cycles;
    cycles = 0;
    while (result_valid !== 1'b1 && cycles < WAIT_LIMIT) begin
      @(posedge clk);
      #1;
      cycles++;
    end
    ok = (result_valid === 1'b1);
  endtask

  task automatic wait_for_done(output bit ok);
    int cycles;
    cycles = 0;
    while (train_done !== 1'b1 && cycles < WAIT_LIMIT) begin
      @(posedge clk);
      #1;
      cycles++;
    end
    ok = (train_done === 1'b1);
  endtask

  initial begin
    bit ok;
    rst_n       = 1'b0;
    train_start = 1'b0;
    cur_name    = "reset";
    exp_center  = '0;
    exp_found   = '0;
    timeouts    = 0;
    for (int b = 0; b < DATA_WIDTH; b++) begin
      win_lo[b] = -1;
      win_hi[b] = -1;
    end
    repeat (2) @(posedge clk);
    #1;
    rst_n = 1'b1;
    repeat (3) @(posedge clk); // idle outputs are watched by the monitor here.
    #1;
    for (int r = 0; r < N_RUNS; r++) begin
      if (timeouts == 0) begin
        load_run(r);
        pulse_start();
        wait_for_result(ok);
        if (!ok) begin
          $display("%s: timed out waiting for the first result", cur_name);
          timeouts++;
        end else begin
          pulse_start(); // lands while busy and has to be ignored.
          wait_for_done(ok);
          if (!ok) begin
            $display("%s: timed out waiting for train_done", cur_name);
            timeouts++;
          end
        end
      end
    end
    repeat (2) @(posedge clk);
    #1;
    $display("errors: %0d from the monitor, %0d from assertions, %0d timeouts", mon_errors,
             i_qdr_phy_train_top.i_qdr_train_properties.fail_count, timeouts);
    if (mon_errors == 0 && timeouts == 0 &&
        i_qdr_phy_train_top.i_qdr_train_properties.fail_count == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: all.f
logic/qdr_cfg_pkg.sv
logic/qdr_train_pkg.sv
logic/qdr_tap_if.sv
logic/qdr_lane_select.sv
logic/qdr_window_check.sv
logic/qdr_train_seq.sv
logic/qdr_phy_train_top.sv
sim/qdr_train_properties.sv
sim/qdr_train_monitor.sv
sim/tb_qdr_train.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Builds the read training testbench with Verilator and runs it.
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_qdr_train -f all.f
build_status=$?
if [ $build_status -ne 0 ]; then
  echo "verilator build failed with status $build_status"
  exit 1
fi

# A failed assertion should not end the run before the closing report.
output=$(./obj_dir/Vtb_qdr_train +verilator+error+limit+1000 2>&1)
run_status=$?
echo "$output"
if [ $run_status -ne 0 ]; then
  echo "simulation exited with status $run_status"
  exit 1
fi

if grep -q "All checks passed" <<< "$output"; then
  exit 0
fi

echo "simulation did not report a pass"
exit 1
